/* list.f */
+incdir+logic
logic/dma_pkg.sv
logic/dma_lane_if.sv
logic/dma_fifo.sv
logic/dma_fanout.sv
logic/dma_bank_lane.sv
logic/dma_mem_arbiter.sv
logic/dma_fabric_top.sv
tb/dma_fabric_sva.sv
tb/dma_fabric_tb.sv

/* logic/dma_bank_lane.sv */
// One bank lane with packet buffer and DRAM address hash on the way out
`include "dma_settings.svh"

module dma_bank_lane
   import dma_pkg::*;
   (
   input  logic    clk_i,
   input  logic    rst_n_i,
   dma_lane_if.dst lane_in,
   dma_lane_if.src lane_out
   );

   localparam int hash_w_lp = $bits(bank_id_t);

   dma_pkt_t head_pkt;
   dma_pkt_t hashed_pkt;

   dma_fifo
      #(.payload_t(dma_pkt_t),
        .depth_p(`DMA_FIFO_DEPTH))
   pkt_fifo
      (.clk_i(clk_i),
       .rst_n_i(rst_n_i),
       .push_v_i(lane_in.v),
       .push_ready_o(lane_in.ready),
       .push_data_i(lane_in.pkt),
       .pop_v_o(lane_out.v),
       .pop_ready_i(lane_out.ready),
       .pop_data_o(head_pkt));

   // Bank bits folded with the bits just above them
   always_comb
   begin
      hashed_pkt = head_pkt;
      hashed_pkt.addr[`DMA_HASH_LSB +: hash_w_lp] =
         head_pkt.addr[`DMA_HASH_LSB +: hash_w_lp] ^
         head_pkt.addr[`DMA_HASH_LSB + hash_w_lp +: hash_w_lp];
   end

   assign lane_out.pkt = hashed_pkt;

endmodule

/* logic/dma_fabric_top.sv */
// DMA bank fabric top with fanout, bank lanes and memory arbiter
`include "dma_settings.svh"

module dma_fabric_top
   import dma_pkg::*;
   (
   input  logic                   clk_i,
   input  logic                   rst_n_i,

   // Request in
   input  logic                   req_v_i,
   output logic                   req_ready_o,
   input  bank_id_t               req_bank_i,
   input  logic                   req_we_i,
   input  logic [`DMA_ADDR_W-1:0] req_addr_i,
   input  logic [`DMA_DATA_W-1:0] req_wdata_i,

   // Memory request out
   output logic                   mem_v_o,
   input  logic                   mem_ready_i,
   output logic                   mem_we_o,
   output logic [`DMA_ADDR_W-1:0] mem_addr_o,
   output logic [`DMA_DATA_W-1:0] mem_wdata_o,

   // In-order read return
   input  logic                   mem_rvalid_i,
   input  logic [`DMA_DATA_W-1:0] mem_rdata_i,

   // Response out
   output logic                   rsp_v_o,
   output bank_id_t               rsp_bank_o,
   output logic [`DMA_DATA_W-1:0] rsp_data_o
   );

   dma_pkt_t req_pkt;

   dma_lane_if lane_in  [`DMA_LANES] ();
   dma_lane_if lane_out [`DMA_LANES] ();

   assign req_pkt.write_not_read = req_we_i;
   assign req_pkt.addr           = req_addr_i;
   assign req_pkt.data           = req_wdata_i;

   dma_fanout fanout
      (.req_v_i(req_v_i),
       .req_ready_o(req_ready_o),
       .req_bank_i(req_bank_i),
       .req_pkt_i(req_pkt),
       .lane_in(lane_in));

   for (genvar i = 0; i < `DMA_LANES; i++)
   begin : bank
      dma_bank_lane lane
         (.clk_i(clk_i),
          .rst_n_i(rst_n_i),
          .lane_in(lane_in[i]),
          .lane_out(lane_out[i]));
   end

   dma_mem_arbiter arbiter
      (.clk_i(clk_i),
       .rst_n_i(rst_n_i),
       .lane_out(lane_out),
       .mem_v_o(mem_v_o),
       .mem_ready_i(mem_ready_i),
       .mem_we_o(mem_we_o),
       .mem_addr_o(mem_addr_o),
       .mem_wdata_o(mem_wdata_o),
       .mem_rvalid_i(mem_rvalid_i),
       .mem_rdata_i(mem_rdata_i),
       .rsp_v_o(rsp_v_o),
       .rsp_bank_o(rsp_bank_o),
       .rsp_data_o(rsp_data_o));

endmodule

/* logic/dma_fanout.sv */
// Steers incoming DMA packets to their bank lane
`include "dma_settings.svh"

module dma_fanout
   import dma_pkg::*;
   (
   input  logic       req_v_i,
   output logic       req_ready_o,
   input  bank_id_t   req_bank_i,
   input  dma_pkt_t   req_pkt_i,
   dma_lane_if.src    lane_in [`DMA_LANES]
   );

   logic [`DMA_LANES-1:0] lane_ready;

   for (genvar i = 0; i < `DMA_LANES; i++)
   begin : lane
      // Packet goes to every lane but only the addressed one sees valid
      assign lane_in[i].pkt = req_pkt_i;
      assign lane_in[i].v   = req_v_i && (req_bank_i == bank_id_t'(i));
      assign lane_ready[i]  = lane_in[i].ready;
   end

   // Back-pressure from the addressed lane only
   assign req_ready_o = lane_ready[req_bank_i];

endmodule

/* logic/dma_fifo.sv */
// Valid/ready FIFO with a parameterized payload type
module dma_fifo
   #(parameter type payload_t = logic,
     parameter int  depth_p   = 4)
   (
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  logic     push_v_i,
   output logic     push_ready_o,
   input  payload_t push_data_i,
   output logic     pop_v_o,
   input  logic     pop_ready_i,
   output payload_t pop_data_o
   );

   localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
   localparam int cnt_w_lp = $clog2(depth_p + 1);

   payload_t            mem_q [depth_p];
   logic [ptr_w_lp-1:0] rd_ptr_q;
   logic [ptr_w_lp-1:0] wr_ptr_q;
   logic [cnt_w_lp-1:0] count_q;
   logic                push_fire;
   logic                pop_fire;

   assign pop_v_o    = (count_q != '0);
   assign pop_data_o = mem_q[rd_ptr_q];

   // Full FIFO still takes a push when the head leaves this cycle
   assign push_ready_o = (count_q != cnt_w_lp'(depth_p)) || pop_ready_i;

   assign push_fire = push_v_i && push_ready_o;
   assign pop_fire  = pop_v_o && pop_ready_i;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         rd_ptr_q <= '0;
         wr_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push_fire)
            wr_ptr_q <= (wr_ptr_q == ptr_w_lp'(depth_p - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (pop_fire)
            rd_ptr_q <= (rd_ptr_q == ptr_w_lp'(depth_p - 1)) ? '0 : rd_ptr_q + 1'b1;
         case ({push_fire, pop_fire})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (push_fire)
         mem_q[wr_ptr_q] <= push_data_i;
   end

endmodule

/* logic/dma_lane_if.sv */
// Packet stream of one bank lane
interface dma_lane_if
   import dma_pkg::*;
   ();

   dma_pkt_t pkt;
   logic     v;
   logic     ready;

   // Producer side
   modport src
   (
      output pkt,
      output v,
      input  ready
   );

   // Consumer side
   modport dst
   (
      input  pkt,
      input  v,
      output ready
   );

endinterface

/* logic/dma_mem_arbiter.sv */
// Round-robin drain of the bank lanes onto the memory port
// Read ids tracked in issue order for the response return
`include "dma_settings.svh"

module dma_mem_arbiter
   import dma_pkg::*;
   (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   dma_lane_if.dst                lane_out [`DMA_LANES],
   output logic                   mem_v_o,
   input  logic                   mem_ready_i,
   output logic                   mem_we_o,
   output logic [`DMA_ADDR_W-1:0] mem_addr_o,
   output logic [`DMA_DATA_W-1:0] mem_wdata_o,
   input  logic                   mem_rvalid_i,
   input  logic [`DMA_DATA_W-1:0] mem_rdata_i,
   output logic                   rsp_v_o,
   output bank_id_t               rsp_bank_o,
   output logic [`DMA_DATA_W-1:0] rsp_data_o
   );

   dma_pkt_t              lane_pkt [`DMA_LANES];
   logic [`DMA_LANES-1:0] lane_v;
   logic [`DMA_LANES-1:0] lane_elig;
   bank_id_t              last_q;
   logic                  hold_q;
   bank_id_t              hold_idx_q;
   bank_id_t              cand_idx;
   bank_id_t              rr_idx;
   logic                  rr_found;
   bank_id_t              grant_idx;
   logic                  grant_v;
   logic                  mem_fire;
   logic                  id_push_v;
   logic                  id_push_ready;
   logic                  id_pop_v;
   bank_id_t              id_head;
   logic                  rsp_v_q;
   bank_id_t              rsp_bank_q;
   logic [`DMA_DATA_W-1:0] rsp_data_q;

   for (genvar i = 0; i < `DMA_LANES; i++)
   begin : lane
      assign lane_v[i]   = lane_out[i].v;
      assign lane_pkt[i] = lane_out[i].pkt;
      // Reads wait for room in the id FIFO
      assign lane_elig[i] = lane_out[i].v &&
                            (lane_out[i].pkt.write_not_read || id_push_ready);
      assign lane_out[i].ready = mem_ready_i && grant_v && (grant_idx == bank_id_t'(i));
   end

   // First eligible lane after the last one served
   always_comb
   begin
      rr_found = 1'b0;
      rr_idx   = last_q;
      cand_idx = last_q;
      for (int k = 1; k <= `DMA_LANES; k++)
      begin
         cand_idx = bank_id_t'((int'(last_q) + k) % `DMA_LANES);
         if (!rr_found && lane_elig[cand_idx])
         begin
            rr_found = 1'b1;
            rr_idx   = cand_idx;
         end
      end
   end

   // A stalled request keeps its lane until memory takes it
   assign grant_idx = hold_q ? hold_idx_q : rr_idx;
   assign grant_v   = hold_q ? lane_v[hold_idx_q] : rr_found;

   assign mem_v_o     = grant_v;
   assign mem_we_o    = lane_pkt[grant_idx].write_not_read;
   assign mem_addr_o  = lane_pkt[grant_idx].addr;
   assign mem_wdata_o = lane_pkt[grant_idx].data;
   assign mem_fire    = mem_v_o && mem_ready_i;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         // Search begins at lane 0
         last_q <= bank_id_t'(`DMA_LANES - 1);
         hold_q <= 1'b0;
      end
      else
      begin
         if (mem_fire)
            last_q <= grant_idx;
         hold_q <= mem_v_o && !mem_ready_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      hold_idx_q <= grant_idx;
   end

   assign id_push_v = mem_fire && !mem_we_o;

   dma_fifo
      #(.payload_t(bank_id_t),
        .depth_p(`DMA_FIFO_DEPTH))
   id_fifo
      (.clk_i(clk_i),
       .rst_n_i(rst_n_i),
       .push_v_i(id_push_v),
       .push_ready_o(id_push_ready),
       .push_data_i(grant_idx),
       .pop_v_o(id_pop_v),
       .pop_ready_i(mem_rvalid_i),
       .pop_data_o(id_head));

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         rsp_v_q <= 1'b0;
      else
         rsp_v_q <= mem_rvalid_i && id_pop_v;
   end

   always_ff @(posedge clk_i)
   begin
      if (mem_rvalid_i)
      begin
         rsp_bank_q <= id_head;
         rsp_data_q <= mem_rdata_i;
      end
   end

   assign rsp_v_o    = rsp_v_q;
   assign rsp_bank_o = rsp_bank_q;
   assign rsp_data_o = rsp_data_q;

endmodule

/* logic/dma_pkg.sv */
// Packet and bank-id types for the DMA bank fabric
`include "dma_settings.svh"

package dma_pkg;

   // Bank number, one per lane
   typedef logic [$clog2(`DMA_LANES)-1:0] bank_id_t;

   // One DMA packet, single data word
   typedef struct packed
   {
      logic                   write_not_read;
      logic [`DMA_ADDR_W-1:0] addr;
      logic [`DMA_DATA_W-1:0] data;
   } dma_pkt_t;

endpackage

/* logic/dma_settings.svh */
// Shared constants for the DMA bank fabric
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// Number of cache-bank lanes
`define DMA_LANES 4

// Packet field widths
`define DMA_ADDR_W 32
`define DMA_DATA_W 32

// Bank field of the DRAM hash sits one 64-byte block up
`define DMA_HASH_LSB 6

// Entries in each lane FIFO and in the read-id FIFO
`define DMA_FIFO_DEPTH 4

`endif

/* run.sh */
#!/bin/sh
# Build and run the DMA fabric testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f list.f \
   --top-module dma_fabric_tb -o sim_dma_fabric
./obj_dir/sim_dma_fabric 2>&1 | tee sim.log
if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log; then
   echo "simulation FAILED, see sim.log"
   exit 1
fi
echo "simulation ok"

/* tb/dma_fabric_sva.sv */
// Concurrent checks on the DMA fabric top-level ports
`include "dma_settings.svh"

module dma_fabric_sva
   (
   input logic                   clk_i,
   input logic                   rst_n_i,
   input logic                   req_ready_i,
   input logic                   mem_v_i,
   input logic                   mem_ready_i,
   input logic                   mem_we_i,
   input logic [`DMA_ADDR_W-1:0] mem_addr_i,
   input logic [`DMA_DATA_W-1:0] mem_wdata_i,
   input logic                   rsp_v_i
   );
   timeunit 1ns;
   timeprecision 1ps;

   int reads_out_q;

   // Reads issued but not yet answered
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         reads_out_q <= 0;
      else
         reads_out_q <= reads_out_q + int'(mem_v_i && mem_ready_i && !mem_we_i) - int'(rsp_v_i);
   end

   a_mem_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_v_i && !mem_ready_i |=> mem_v_i && $stable(mem_we_i) && $stable(mem_addr_i) &&
         $stable(mem_wdata_i))
      else $error("memory request changed while stalled");

   a_rsp_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_v_i |-> reads_out_q != 0)
      else $error("response without an outstanding read");

   a_reset_values: assert property (@(posedge clk_i)
      $rose(rst_n_i) |-> !mem_v_i && req_ready_i && !rsp_v_i)
      else $error("outputs not at reset values after reset");

endmodule

bind dma_fabric_top dma_fabric_sva sva0
   (.clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .req_ready_i(req_ready_o),
    .mem_v_i(mem_v_o),
    .mem_ready_i(mem_ready_i),
    .mem_we_i(mem_we_o),
    .mem_addr_i(mem_addr_o),
    .mem_wdata_i(mem_wdata_o),
    .rsp_v_i(rsp_v_o));

/* tb/dma_fabric_tb.sv */
// DMA fabric testbench with clock, reset, memory model, scoreboard and directed tests
`include "dma_settings.svh"

module dma_fabric_tb
   import dma_pkg::*;
   ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int bank_w_lp   = $bits(bank_id_t);
   localparam int off_w_lp    = `DMA_ADDR_W - bank_w_lp;
   localparam int wait_lim_lp = 400;

   logic                   clk_i;
   logic                   rst_n_i;
   logic                   req_v_i;
   logic                   req_ready_o;
   bank_id_t               req_bank_i;
   logic                   req_we_i;
   logic [`DMA_ADDR_W-1:0] req_addr_i;
   logic [`DMA_DATA_W-1:0] req_wdata_i;
   logic                   mem_v_o;
   logic                   mem_ready_i;
   logic                   mem_we_o;
   logic [`DMA_ADDR_W-1:0] mem_addr_o;
   logic [`DMA_DATA_W-1:0] mem_wdata_o;
   logic                   mem_rvalid_i;
   logic [`DMA_DATA_W-1:0] mem_rdata_i;
   logic                   rsp_v_o;
   bank_id_t               rsp_bank_o;
   logic [`DMA_DATA_W-1:0] rsp_data_o;

   int          seed = 32'h44b7e037;
   int          errors = 0;
   int          tests = 0;
   // 0 always ready, 1 held low, 2 stall pattern
   int          ready_mode = 0;
   logic [63:0] stall_bits = '1;
   int          stall_idx = 0;

   // Expected traffic per bank with memory side addresses already hashed
   dma_pkt_t               exp_mem_q [`DMA_LANES][$];
   logic [`DMA_DATA_W-1:0] exp_rsp_q [`DMA_LANES][$];
   logic [`DMA_DATA_W-1:0] rd_data_q [$];
   bank_id_t               issue_q [$];
   logic [`DMA_DATA_W-1:0] model_mem [logic [`DMA_ADDR_W-1:0]];
   logic [`DMA_DATA_W-1:0] ref_mem [logic [`DMA_ADDR_W-1:0]];

   dma_fabric_top dut0 (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   function automatic logic [`DMA_ADDR_W-1:0] hash_addr(input logic [`DMA_ADDR_W-1:0] a);
      logic [`DMA_ADDR_W-1:0] h;
      h = a;
      h[`DMA_HASH_LSB +: 2] = a[`DMA_HASH_LSB +: 2] ^ a[`DMA_HASH_LSB + 2 +: 2];
      return h;
   endfunction

   // Unwritten words read back a pattern of their whole address
   function automatic logic [`DMA_DATA_W-1:0] fill_word(input logic [`DMA_ADDR_W-1:0] a);
      return {a[15:0], a[31:16]} ^ 32'hc3a5_0f1e;
   endfunction

   // Top address bits name the bank, so hashed addresses tell banks apart
   function automatic logic [`DMA_ADDR_W-1:0] bank_addr(input bank_id_t bank, input int off);
      return {bank, off_w_lp'(off)};
   endfunction

   function automatic bit queues_empty();
      for (int b = 0; b < `DMA_LANES; b++)
         if (exp_mem_q[b].size() != 0 || exp_rsp_q[b].size() != 0)
            return 1'b0;
      return 1'b1;
   endfunction

   task automatic check_word(input string name, input logic [`DMA_DATA_W-1:0] exp,
                             input logic [`DMA_DATA_W-1:0] got);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   // Memory model, response monitor and memory-port scoreboard
   initial
   begin
      dma_pkt_t exp;
      bank_id_t bank;
      mem_ready_i  = 1'b1;
      mem_rvalid_i = 1'b0;
      mem_rdata_i  = '0;
      forever
      begin
         @(negedge clk_i);
         mem_rvalid_i = (rd_data_q.size() != 0);
         if (mem_rvalid_i)
            mem_rdata_i = rd_data_q.pop_front();
         if (ready_mode == 2)
         begin
            mem_ready_i = stall_bits[stall_idx % 64];
            stall_idx++;
         end
         else
            mem_ready_i = (ready_mode == 0);
         #5;
         if (rst_n_i && rsp_v_o)
         begin
            if (exp_rsp_q[rsp_bank_o].size() == 0)
            begin
               $display("Error at %0t: response on bank %0d with no read pending", $time,
                        rsp_bank_o);
               errors++;
            end
            else
               check_word("rsp_data_o", exp_rsp_q[rsp_bank_o].pop_front(), rsp_data_o);
         end
         if (rst_n_i && mem_v_o && mem_ready_i)
         begin
            bank = mem_addr_o[`DMA_ADDR_W-1 -: bank_w_lp];
            issue_q.push_back(bank);
            if (exp_mem_q[bank].size() == 0)
            begin
               $display("Error at %0t: memory request for bank %0d never sent", $time, bank);
               errors++;
            end
            else
            begin
               exp = exp_mem_q[bank].pop_front();
               check_word("mem_we_o", exp.write_not_read, mem_we_o);
               check_word("mem_addr_o", exp.addr, mem_addr_o);
               if (exp.write_not_read)
                  check_word("mem_wdata_o", exp.data, mem_wdata_o);
            end
            if (mem_we_o)
               model_mem[mem_addr_o] = mem_wdata_o;
            else if (model_mem.exists(mem_addr_o))
               rd_data_q.push_back(model_mem[mem_addr_o]);
            else
               rd_data_q.push_back(fill_word(mem_addr_o));
         end
      end
   end

   task automatic send_req(input bank_id_t bank, input logic we,
                           input logic [`DMA_ADDR_W-1:0] addr, input logic [`DMA_DATA_W-1:0] data);
      dma_pkt_t pkt;
      int       waited;
      @(negedge clk_i);
      req_v_i     = 1'b1;
      req_bank_i  = bank;
      req_we_i    = we;
      req_addr_i  = addr;
      req_wdata_i = data;
      waited      = 0;
      #10;
      while (!req_ready_o && waited < wait_lim_lp)
      begin
         @(negedge clk_i);
         #10;
         waited++;
      end
      if (!req_ready_o)
      begin
         $display("Error at %0t: request to bank %0d never accepted", $time, bank);
         errors++;
      end
      else
      begin
         pkt.write_not_read = we;
         pkt.addr           = hash_addr(addr);
         pkt.data           = data;
         exp_mem_q[bank].push_back(pkt);
         if (we)
            ref_mem[pkt.addr] = data;
         else if (ref_mem.exists(pkt.addr))
            exp_rsp_q[bank].push_back(ref_mem[pkt.addr]);
         else
            exp_rsp_q[bank].push_back(fill_word(pkt.addr));
         @(posedge clk_i);
      end
      @(negedge clk_i);
      req_v_i = 1'b0;
   endtask

   task automatic wait_drain(input string name);
      int waited;
      waited = 0;
      while (!queues_empty() && waited < wait_lim_lp)
      begin
         @(negedge clk_i);
         #10;
         waited++;
      end
      if (!queues_empty())
      begin
         $display("Error at %0t: %s left requests or responses outstanding", $time, name);
         errors++;
      end
   endtask

   task automatic finish_test(input string name, input int err0);
      tests++;
      wait_drain(name);
      $display("%s: finished with %0d errors", name, errors - err0);
   endtask

   task automatic test_write_each_bank();
      int err0 = errors;
      ready_mode = 0;
      for (int b = 0; b < `DMA_LANES; b++)
         send_req(bank_id_t'(b), 1'b1, bank_addr(bank_id_t'(b), 'h2c0 + b * 'h140),
                  32'h1000_0000 + b);
      finish_test("write to each bank", err0);
   endtask

   task automatic test_read_after_write();
      int err0 = errors;
      for (int b = 0; b < `DMA_LANES; b++)
      begin
         send_req(bank_id_t'(b), 1'b1, bank_addr(bank_id_t'(b), 'h3c4), 32'hd00d_0000 + b);
         send_req(bank_id_t'(b), 1'b0, bank_addr(bank_id_t'(b), 'h3c4), '0);
      end
      finish_test("read after write", err0);
   endtask

   task automatic test_round_robin();
      bank_id_t load [4] = '{3, 1, 0, 2};
      // Bank 3 arrives alone and keeps the stalled port, then 0, 1, 2 follow
      bank_id_t order [4] = '{3, 0, 1, 2};
      int       err0 = errors;
      ready_mode = 1;
      issue_q.delete();
      foreach (load[i])
         send_req(load[i], 1'b1, bank_addr(load[i], 'h100 + i * 'h40), 32'hbeef_0000 + i);
      ready_mode = 0;
      wait_drain("round robin");
      if (issue_q.size() != 4)
      begin
         $display("Error at %0t: %0d grants seen instead of 4", $time, issue_q.size());
         errors++;
      end
      else
         foreach (order[i])
            check_word("grant bank", order[i], issue_q[i]);
      finish_test("round robin", err0);
   endtask

   task automatic test_lane_full();
      int err0 = errors;
      ready_mode = 1;
      for (int i = 0; i < `DMA_FIFO_DEPTH; i++)
         send_req(2'd2, 1'b1, bank_addr(2'd2, 'h200 + i * 4), 32'h4000_0000 + i);
      @(negedge clk_i);
      req_bank_i = 2'd2;
      #10;
      check_word("req_ready_o bank 2", 1'b0, req_ready_o);
      @(negedge clk_i);
      req_bank_i = 2'd1;
      #10;
      check_word("req_ready_o bank 1", 1'b1, req_ready_o);
      ready_mode = 0;
      finish_test("lane full", err0);
   endtask

   task automatic test_random_mix();
      int       err0 = errors;
      int       r;
      bank_id_t bank;
      // About three ready cycles in four
      stall_bits = {$random(seed), $random(seed)} | {$random(seed), $random(seed)};
      stall_idx  = 0;
      ready_mode = 2;
      for (int n = 0; n < 48; n++)
      begin
         r    = $random(seed);
         bank = bank_id_t'(r[1:0]);
         send_req(bank, r[2], bank_addr(bank, {r[6:3], 6'h00}), $random(seed));
      end
      ready_mode = 0;
      finish_test("random mix", err0);
   endtask

   initial
   begin
      rst_n_i     = 1'b0;
      req_v_i     = 1'b0;
      req_bank_i  = '0;
      req_we_i    = 1'b0;
      req_addr_i  = '0;
      req_wdata_i = '0;
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;
      test_write_each_bank();
      test_read_after_write();
      test_round_robin();
      test_lane_full();
      test_random_mix();
      $display("tests run %0d, errors %0d", tests, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule
